//--- src.f
rtl/cpu_pkg.sv
rtl/reg_file.sv
rtl/operand_bypass.sv
rtl/fetch_pc.sv
rtl/flag_select.sv
rtl/operand_stage.sv
tests/operand_stage_chk.sv
tests/operand_stage_tb.sv

//--- tests/operand_stage_tb.sv
`timescale 1ns/1ps

module operand_stage_tb;

    // The tests need about 400 cycles
    localparam int TIMEOUT_CYCLES = 2000;

    logic clk = 1'b0;
    logic rst;
    logic fetch_next;
    logic flush;
    logic lane0_loads;
    logic lane1_loads;
    cpu_pkg::bypass_t lane0_s2;
    cpu_pkg::bypass_t lane1_s2;
    cpu_pkg::bypass_t lane0_s3;
    cpu_pkg::bypass_t lane1_s3;
    cpu_pkg::bypass_t lane0_wb;
    cpu_pkg::bypass_t lane1_wb;
    cpu_pkg::read_nums_t lane0_nums;
    cpu_pkg::read_nums_t lane1_nums;
    cpu_pkg::flags_t lane0_flags;
    cpu_pkg::flags_t lane1_flags;
    cpu_pkg::operands_t lane0_ops;
    cpu_pkg::operands_t lane1_ops;
    cpu_pkg::im_addr_t slot0_addr;
    cpu_pkg::im_addr_t slot1_addr;
    cpu_pkg::flags_t flags;
    logic flag_lane;

    int errors = 0;
    int cycles = 0;
    logic [31:0] lcg_state = 32'hdafc;
    logic exp_flag_lane = 1'b0;
    cpu_pkg::data_t reg_model [cpu_pkg::NUM_REGS];
    // Source data in priority order: lane1 s2, lane0 s2, lane1 s3, lane0 s3, lane1 wb, lane0 wb
    cpu_pkg::data_t src_data [6];

    operand_stage DUT (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // ------------------------------
    // Helpers
    // ------------------------------

    function automatic cpu_pkg::data_t next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[23:8];
    endfunction

    function automatic cpu_pkg::bypass_t make_src(input logic write, input cpu_pkg::reg_num_t num,
                                                  input cpu_pkg::data_t data);
        cpu_pkg::bypass_t src;
        src.write = write;
        src.num = num;
        src.data = data;
        return src;
    endfunction

    // First enabled source in priority order, else the stored value
    function automatic cpu_pkg::data_t expected_operand(input logic [5:0] hits,
                                                        input cpu_pkg::reg_num_t req);
        for (int i = 0; i < 6; i++) begin
            if (hits[i]) begin
                return src_data[i];
            end
        end
        return reg_model[req];
    endfunction

    task automatic check_word(input string test, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %h, actual %h", test, expected, actual);
            errors++;
        end
    endtask

    task automatic check_slots(input string test, input int strobes);
        cpu_pkg::im_addr_t exp_addr;
        exp_addr = cpu_pkg::im_addr_t'((2 * strobes) % 256);
        check_word({test, " slot0"}, exp_addr, slot0_addr);
        check_word({test, " slot1"}, exp_addr + 1, slot1_addr);
    endtask

    task automatic apply_sources(input logic [5:0] mask, input cpu_pkg::reg_num_t num);
        lane1_s2 <= make_src(mask[0], num, src_data[0]);
        lane0_s2 <= make_src(mask[1], num, src_data[1]);
        lane1_s3 <= make_src(mask[2], num, src_data[2]);
        lane0_s3 <= make_src(mask[3], num, src_data[3]);
        lane1_wb <= make_src(mask[4], num, src_data[4]);
        lane0_wb <= make_src(mask[5], num, src_data[5]);
    endtask

    task automatic clear_inputs();
        apply_sources(6'b0, 3'd0);
        lane0_nums <= '0;
        lane1_nums <= '0;
        lane0_flags <= '0;
        lane1_flags <= '0;
        lane0_loads <= 1'b0;
        lane1_loads <= 1'b0;
        flush <= 1'b0;
        fetch_next <= 1'b0;
    endtask

    // ------------------------------
    // Tests
    // ------------------------------

    task automatic test_fetch();
        int strobes;
        strobes = 0;
        @(negedge clk);
        check_slots("fetch after reset", strobes);
        check_word("flag lane after reset", 32'd0, flag_lane);
        // 130 pairs, so the PC wraps once
        for (int i = 0; i < 130; i++) begin
            @(posedge clk);
            fetch_next <= 1'b1;
            @(posedge clk);
            fetch_next <= 1'b0;
            strobes++;
            @(negedge clk);
            check_slots("fetch strobe", strobes);
            if (i % 8 == 7) begin
                @(negedge clk);
                check_slots("fetch idle", strobes);
            end
        end
    endtask

    task automatic test_reg_rw();
        cpu_pkg::reg_num_t r;
        for (int i = 0; i < cpu_pkg::NUM_REGS; i++) begin
            r = cpu_pkg::reg_num_t'(i);
            reg_model[i] = next_random();
            @(posedge clk);
            lane0_wb <= make_src(1'b1, r, reg_model[i]);
        end
        @(posedge clk);
        lane0_wb <= '0;
        for (int i = 0; i < cpu_pkg::NUM_REGS; i++) begin
            r = cpu_pkg::reg_num_t'(i);
            @(posedge clk);
            lane0_nums <= {r, r + 3'd1, r + 3'd2};
            lane1_nums <= {r + 3'd3, r + 3'd4, r + 3'd5};
            @(negedge clk);
            check_word("reg_rw lane0 rm", reg_model[r], lane0_ops.rm);
            check_word("reg_rw lane0 rn", reg_model[r + 3'd1], lane0_ops.rn);
            check_word("reg_rw lane0 rd", reg_model[r + 3'd2], lane0_ops.rd);
            check_word("reg_rw lane1 rm", reg_model[r + 3'd3], lane1_ops.rm);
            check_word("reg_rw lane1 rn", reg_model[r + 3'd4], lane1_ops.rn);
            check_word("reg_rw lane1 rd", reg_model[r + 3'd5], lane1_ops.rd);
        end
    endtask

    task automatic test_dual_write();
        cpu_pkg::data_t d0;
        cpu_pkg::data_t d1;
        d0 = next_random();
        d1 = ~d0;
        @(posedge clk);
        lane0_wb <= make_src(1'b1, 3'd5, d0);
        lane1_wb <= make_src(1'b1, 3'd5, d1);
        reg_model[5] = d1;
        @(posedge clk);
        lane0_wb <= '0;
        lane1_wb <= '0;
        lane0_nums <= {3'd5, 3'd5, 3'd5};
        lane1_nums <= {3'd5, 3'd4, 3'd5};
        @(negedge clk);
        check_word("dual_write lane0 rm", d1, lane0_ops.rm);
        check_word("dual_write lane1 rd", d1, lane1_ops.rd);
        check_word("dual_write neighbour", reg_model[4], lane1_ops.rn);
    endtask

    task automatic test_forwarding();
        cpu_pkg::reg_num_t req;
        cpu_pkg::reg_num_t other;
        logic [5:0] mask;
        logic [5:0] hits;
        cpu_pkg::data_t exp_val;
        for (int m = 0; m < 66; m++) begin
            mask = (m < 64) ? 6'(m) : 6'h3f;
            req = next_random() % 8;
            // Last two passes aim every source at another register
            other = (m < 64) ? req : req ^ 3'(m - 62);
            for (int i = 0; i < 6; i++) begin
                src_data[i] = (next_random() & 16'h0fff) | cpu_pkg::data_t'((i + 1) << 12);
            end
            @(posedge clk);
            apply_sources(mask, other);
            lane0_nums <= {req, req, req};
            lane1_nums <= {req, req ^ 3'd4, req};
            @(negedge clk);
            hits = (other == req) ? mask : 6'b0;
            exp_val = expected_operand(hits, req);
            check_word("forwarding lane0 rm", exp_val, lane0_ops.rm);
            check_word("forwarding lane0 rn", exp_val, lane0_ops.rn);
            check_word("forwarding lane0 rd", exp_val, lane0_ops.rd);
            check_word("forwarding lane1 rm", exp_val, lane1_ops.rm);
            check_word("forwarding lane1 rn", reg_model[req ^ 3'd4], lane1_ops.rn);
            check_word("forwarding lane1 rd", exp_val, lane1_ops.rd);
            // Writebacks land at the next edge, lane 1 last
            if (mask[5]) begin
                reg_model[other] = src_data[5];
            end
            if (mask[4]) begin
                reg_model[other] = src_data[4];
            end
        end
        @(posedge clk);
        apply_sources(6'b0, 3'd0);
    endtask

    task automatic pulse_loads(input logic l1, input logic l0, input logic fl);
        cpu_pkg::data_t rnd;
        cpu_pkg::flags_t f0;
        cpu_pkg::flags_t f1;
        rnd = next_random();
        f0 = rnd[2:0];
        f1 = ~f0;
        @(posedge clk);
        lane0_flags <= f0;
        lane1_flags <= f1;
        lane0_loads <= l0;
        lane1_loads <= l1;
        flush <= fl;
        @(posedge clk);
        lane0_loads <= 1'b0;
        lane1_loads <= 1'b0;
        flush <= 1'b0;
        if (!fl && l1) begin
            exp_flag_lane = 1'b1;
        end else if (!fl && l0) begin
            exp_flag_lane = 1'b0;
        end
        @(negedge clk);
        check_word(fl ? "flags flush lane" : "flags lane", exp_flag_lane, flag_lane);
        check_word("flags value", exp_flag_lane ? f1 : f0, flags);
    endtask

    task automatic test_flags();
        pulse_loads(1'b0, 1'b1, 1'b0);
        pulse_loads(1'b1, 1'b0, 1'b0);
        pulse_loads(1'b0, 1'b0, 1'b0);
        pulse_loads(1'b0, 1'b1, 1'b0);
        pulse_loads(1'b1, 1'b1, 1'b0);
        pulse_loads(1'b0, 1'b0, 1'b0);
        // Flushed loads must leave the tracker alone
        pulse_loads(1'b0, 1'b1, 1'b1);
        pulse_loads(1'b0, 1'b1, 1'b0);
        pulse_loads(1'b1, 1'b0, 1'b1);
        pulse_loads(1'b1, 1'b1, 1'b1);
    endtask

    initial begin
        clear_inputs();
        rst <= 1'b1;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        test_fetch();
        test_reg_rw();
        test_dual_write();
        test_forwarding();
        test_flags();
        repeat (2) @(posedge clk);
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- tests/operand_stage_chk.sv
`timescale 1ns/1ps

module operand_stage_chk (
    input  logic clk,
    input  logic rst,
    input  logic flush,
    input  logic lane0_loads,
    input  logic lane1_loads,
    input  logic flag_lane,
    input  cpu_pkg::im_addr_t slot0_addr,
    input  cpu_pkg::im_addr_t slot1_addr
);

    // ------------------------------
    // Fetch pair
    // ------------------------------

    slot_pair: assert property (@(posedge clk) disable iff (rst)
        (slot0_addr ^ slot1_addr) == cpu_pkg::im_addr_t'(1))
        else $error("slot addresses differ in more than bit 0");

    // ------------------------------
    // Flag tracker
    // ------------------------------

    // Joint load leaves lane 1 newest
    joint_load: assert property (@(posedge clk) disable iff (rst)
        (!flush && lane0_loads && lane1_loads) |=> flag_lane)
        else $error("flag lane not 1 after a joint load");

    flush_hold: assert property (@(posedge clk) disable iff (rst)
        flush |=> $stable(flag_lane))
        else $error("flag lane changed during flush");

endmodule

bind operand_stage operand_stage_chk u_chk (.*);

//--- rtl/operand_stage.sv
`timescale 1ns/1ps

module operand_stage (
    input  logic clk,
    input  logic rst,

    // In-flight results of both lanes
    input  cpu_pkg::bypass_t lane0_s2,
    input  cpu_pkg::bypass_t lane1_s2,
    input  cpu_pkg::bypass_t lane0_s3,
    input  cpu_pkg::bypass_t lane1_s3,
    input  cpu_pkg::bypass_t lane0_wb,
    input  cpu_pkg::bypass_t lane1_wb,

    // Operand requests
    input  cpu_pkg::read_nums_t lane0_nums,
    input  cpu_pkg::read_nums_t lane1_nums,

    // Flag sources
    input  cpu_pkg::flags_t lane0_flags,
    input  cpu_pkg::flags_t lane1_flags,
    input  logic lane0_loads,
    input  logic lane1_loads,
    input  logic flush,

    // Fetch strobe
    input  logic fetch_next,

    output cpu_pkg::operands_t lane0_ops,
    output cpu_pkg::operands_t lane1_ops,
    output cpu_pkg::im_addr_t slot0_addr,
    output cpu_pkg::im_addr_t slot1_addr,
    output cpu_pkg::flags_t flags,
    output logic flag_lane
);

    // Stored values before forwarding
    cpu_pkg::operands_t rf_vals0;
    cpu_pkg::operands_t rf_vals1;

    // ------------------------------
    // Register file
    // ------------------------------

    reg_file u_reg_file (
        .clk      (clk),
        .wr0      (lane0_wb),
        .wr1      (lane1_wb),
        .rd_nums0 (lane0_nums),
        .rd_nums1 (lane1_nums),
        .rd_data0 (rf_vals0),
        .rd_data1 (rf_vals1)
    );

    // ------------------------------
    // Forwarding, one unit per lane
    // ------------------------------

    operand_bypass u_bypass0 (
        .nums     (lane0_nums),
        .reg_vals (rf_vals0),
        .s2_l1    (lane1_s2),
        .s2_l0    (lane0_s2),
        .s3_l1    (lane1_s3),
        .s3_l0    (lane0_s3),
        .wb_l1    (lane1_wb),
        .wb_l0    (lane0_wb),
        .ops      (lane0_ops)
    );

    // Same sources and order as lane 0
    operand_bypass u_bypass1 (
        .nums     (lane1_nums),
        .reg_vals (rf_vals1),
        .s2_l1    (lane1_s2),
        .s2_l0    (lane0_s2),
        .s3_l1    (lane1_s3),
        .s3_l0    (lane0_s3),
        .wb_l1    (lane1_wb),
        .wb_l0    (lane0_wb),
        .ops      (lane1_ops)
    );

    // ------------------------------
    // Fetch addressing
    // ------------------------------

    fetch_pc u_fetch_pc (
        .clk        (clk),
        .rst        (rst),
        .fetch_next (fetch_next),
        .slot0_addr (slot0_addr),
        .slot1_addr (slot1_addr)
    );

    // ------------------------------
    // Flags
    // ------------------------------

    flag_select u_flag_select (
        .clk         (clk),
        .rst         (rst),
        .lane0_loads (lane0_loads),
        .lane1_loads (lane1_loads),
        .flush       (flush),
        .lane0_flags (lane0_flags),
        .lane1_flags (lane1_flags),
        .flag_lane   (flag_lane),
        .flags       (flags)
    );

endmodule

//--- rtl/flag_select.sv
`timescale 1ns/1ps

module flag_select (
    input  logic clk,
    input  logic rst,

    // Flag-load strobes of the two lanes
    input  logic lane0_loads,
    input  logic lane1_loads,

    // Branch flush freezes the tracker
    input  logic flush,

    input  cpu_pkg::flags_t lane0_flags,
    input  cpu_pkg::flags_t lane1_flags,

    output logic flag_lane,
    output cpu_pkg::flags_t flags
);

    // ------------------------------
    // Newest-flag tracker
    // ------------------------------

    // Lane 1 is younger, so a joint load leaves its flags newest
    always_ff @(posedge clk) begin
        if (rst) begin
            flag_lane <= 1'b0;
        end else if (!flush) begin
            case ({lane1_loads, lane0_loads})
                2'b01: flag_lane <= 1'b0;
                2'b10: flag_lane <= 1'b1;
                2'b11: flag_lane <= 1'b1;
                default: flag_lane <= flag_lane;
            endcase
        end
    end

    // ------------------------------
    // Flag mux
    // ------------------------------

    // Live values of the tracked lane
    assign flags = flag_lane ? lane1_flags : lane0_flags;

endmodule

//--- rtl/fetch_pc.sv
`timescale 1ns/1ps

module fetch_pc (
    input  logic clk,
    input  logic rst,
    input  logic fetch_next,

    // Even and odd instruction slots of the current pair
    output cpu_pkg::im_addr_t slot0_addr,
    output cpu_pkg::im_addr_t slot1_addr
);

    logic [cpu_pkg::PC_W-1:0] pc;

    // Moves one pair per strobe, wraps naturally at the PC width
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (fetch_next) begin
            pc <= pc + cpu_pkg::PC_W'(2);
        end
    end

    // Pair base with the slot bit appended, upper half of memory unused
    assign slot0_addr = {1'b0, pc[cpu_pkg::PC_W-1:1], 1'b0};
    assign slot1_addr = {1'b0, pc[cpu_pkg::PC_W-1:1], 1'b1};

endmodule

//--- rtl/operand_bypass.sv
`timescale 1ns/1ps

module operand_bypass (
    // Requested registers and their stored values
    input  cpu_pkg::read_nums_t nums,
    input  cpu_pkg::operands_t reg_vals,

    // In-flight results, listed from highest to lowest priority
    input  cpu_pkg::bypass_t s2_l1,
    input  cpu_pkg::bypass_t s2_l0,
    input  cpu_pkg::bypass_t s3_l1,
    input  cpu_pkg::bypass_t s3_l0,
    input  cpu_pkg::bypass_t wb_l1,
    input  cpu_pkg::bypass_t wb_l0,

    output cpu_pkg::operands_t ops
);

    localparam int NUM_SRCS = 6;

    // Index 0 is the youngest result
    cpu_pkg::bypass_t [NUM_SRCS-1:0] srcs;

    assign srcs[0] = s2_l1;
    assign srcs[1] = s2_l0;
    assign srcs[2] = s3_l1;
    assign srcs[3] = s3_l0;
    assign srcs[4] = wb_l1;
    assign srcs[5] = wb_l0;

    // ------------------------------
    // Priority pick
    // ------------------------------

    // Walk from oldest to youngest so the youngest match is left standing
    function automatic cpu_pkg::data_t pick(
        input cpu_pkg::reg_num_t num,
        input cpu_pkg::data_t reg_val,
        input cpu_pkg::bypass_t [NUM_SRCS-1:0] cand
    );
        cpu_pkg::data_t result;
        result = reg_val;
        for (int i = NUM_SRCS - 1; i >= 0; i--) begin
            if (cand[i].write && (cand[i].num == num)) begin
                result = cand[i].data;
            end
        end
        return result;
    endfunction

    // ------------------------------
    // Operands
    // ------------------------------

    // Same rule for Rm, Rn and Rd
    always_comb begin
        ops.rm = pick(nums.rm, reg_vals.rm, srcs);
        ops.rn = pick(nums.rn, reg_vals.rn, srcs);
        ops.rd = pick(nums.rd, reg_vals.rd, srcs);
    end

endmodule

//--- rtl/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic clk,

    // Writeback ports, lane 1 is wr1
    input  cpu_pkg::bypass_t wr0,
    input  cpu_pkg::bypass_t wr1,

    // Three reads per lane
    input  cpu_pkg::read_nums_t rd_nums0,
    input  cpu_pkg::read_nums_t rd_nums1,
    output cpu_pkg::operands_t rd_data0,
    output cpu_pkg::operands_t rd_data1
);

    cpu_pkg::data_t regs [cpu_pkg::NUM_REGS];

    // ------------------------------
    // Write side
    // ------------------------------

    // Lane 1 is the younger instruction of the pair
    // Its write comes last so it wins on equal numbers
    always_ff @(posedge clk) begin
        if (wr0.write) begin
            regs[wr0.num] <= wr0.data;
        end
        if (wr1.write) begin
            regs[wr1.num] <= wr1.data;
        end
    end

    // ------------------------------
    // Read side
    // ------------------------------

    // Plain array reads, forwarding of the current writeback is done
    // by the bypass units
    always_comb begin
        rd_data0.rm = regs[rd_nums0.rm];
        rd_data0.rn = regs[rd_nums0.rn];
        rd_data0.rd = regs[rd_nums0.rd];
    end

    always_comb begin
        rd_data1.rm = regs[rd_nums1.rm];
        rd_data1.rn = regs[rd_nums1.rn];
        rd_data1.rd = regs[rd_nums1.rd];
    end

endmodule

//--- rtl/cpu_pkg.sv
package cpu_pkg;

    // ------------------------------
    // Widths and sizes
    // ------------------------------

    // Data path
    localparam int DATA_W = 16;

    // Register file
    localparam int REG_NUM_W = 3;
    localparam int NUM_REGS = 8;

    // Fetch side, PC counts bytes of a pair-aligned program
    localparam int PC_W = 8;
    localparam int IM_ADDR_W = 9;

    // ------------------------------
    // Scalar types
    // ------------------------------

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [REG_NUM_W-1:0] reg_num_t;
    typedef logic [IM_ADDR_W-1:0] im_addr_t;

    // ------------------------------
    // Grouped signals
    // ------------------------------

    // One in-flight result, also used as a register-file write port
    typedef struct packed {
        logic write;
        reg_num_t num;
        data_t data;
    } bypass_t;

    // Register numbers one lane asks for
    typedef struct packed {
        reg_num_t rm;
        reg_num_t rn;
        reg_num_t rd;
    } read_nums_t;

    // Operand values of one lane, same field order as read_nums_t
    typedef struct packed {
        data_t rm;
        data_t rn;
        data_t rd;
    } operands_t;

    // Condition flags
    typedef struct packed {
        logic n;
        logic v;
        logic z;
    } flags_t;

endpackage
